// File: common/dcachePkg.sv
// shared definitions for the data cache
//   word and address widths, cache geometry
//   tag, index and word types
//   address split into tag, index, block offset and byte offset
//   controller state enum
package dcachePkg;

   localparam int wordW    = 32;
   localparam int nSets    = 8;
   localparam int idxW     = 3;
   localparam int tagW     = 26;
   localparam int byteOffW = 2;
   localparam int lastSet  = 7;   // final set visited by flush

   typedef logic [wordW-1:0] wordT;
   typedef logic [tagW-1:0]  tagT;
   typedef logic [idxW-1:0]  idxT;

   // one block offset bit selects the word in a two-word block
   typedef struct packed
   {
      tagT                 tag;
      idxT                 idx;
      logic                blkOff;
      logic [byteOffW-1:0] byteOff;
   } cacheAddrT;

   typedef enum logic [2:0]
   {
      idle,
      writeBack1,
      writeBack2,
      fill1,
      fill2,
      flush1,
      flush2,
      halted
   } cacheStateT;

endpackage

// File: dcache/dcacheTop.sv
// data cache top level
//   two-way set-associative, write-back, eight sets of two-word blocks
//   connects tag lookup, frame storage, miss controller and bus driver
`timescale 1ns/1ps

module dcacheTop
   import dcachePkg::*;
(
   input  logic CLK,
   input  logic nRST,
   input  logic dmemREN,
   input  logic dmemWEN,
   input  logic halt,
   input  wordT dmemaddr,
   input  wordT dmemstore,
   output logic dhit,
   output logic flushed,
   output wordT dmemload,
   output logic dREN,
   output logic dWEN,
   output wordT daddr,
   output wordT dstore,
   input  wordT dload,
   input  logic dwait
);

   tagT        wayTag [2];
   logic [1:0] wayValid;
   logic [1:0] wayDirty;
   logic       lru;
   wordT       wayData [2][2];
   logic       hit, hitWay, victimWay, victimDirty;
   cacheStateT state;
   logic       curWay, fillEn, fillOther, cpuStoreEn, lruEn, flushInvEn;
   idxT        flushSet;
   logic       flushWay;
   tagT        flushTag;
   logic       flushValid, flushDirty;
   wordT       flushData [2];

   tagLookup lookup (.*);

   frameStore frames (.*);

   missControl control (.*);

   memPort bus (.*);

endmodule

// File: dcache/frameStore.sv
// cache frame storage
//   tags, data words, valid and dirty bits per way
//   one recency bit per set, pointing at the least recent way
//   request set read port, flush read port and the load word mux
`timescale 1ns/1ps

module frameStore
   import dcachePkg::*;
(
   input  logic       CLK,
   input  logic       nRST,
   input  wordT       dmemaddr,
   input  wordT       dmemstore,
   input  wordT       dload,
   input  logic       curWay,
   input  logic       fillEn,
   input  logic       fillOther,
   input  logic       cpuStoreEn,
   input  logic       lruEn,
   input  logic       flushInvEn,
   input  idxT        flushSet,
   input  logic       flushWay,
   output tagT        wayTag [2],
   output logic [1:0] wayValid,
   output logic [1:0] wayDirty,
   output logic       lru,
   output wordT       wayData [2][2],
   output tagT        flushTag,
   output logic       flushValid,
   output logic       flushDirty,
   output wordT       flushData [2],
   output wordT       dmemload
);

   tagT        tagArr  [nSets][2];
   wordT       dataArr [nSets][2][2];
   logic [1:0] validArr [nSets];
   logic [1:0] dirtyArr [nSets];
   logic       lruArr   [nSets];
   cacheAddrT  addr;
   logic       fillWord;

   assign addr     = cacheAddrT'(dmemaddr);
   assign fillWord = fillOther ? ~addr.blkOff : addr.blkOff;

   always_ff @(posedge CLK)
   begin
      if (fillEn)
      begin
         tagArr[addr.idx][curWay] <= addr.tag;
         dataArr[addr.idx][curWay][fillWord] <= dload;
      end
      if (cpuStoreEn)   // overrides the fill word on a write miss
      begin
         dataArr[addr.idx][curWay][addr.blkOff] <= dmemstore;
      end
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         validArr <= '{default: '0};
         dirtyArr <= '{default: '0};
         lruArr   <= '{default: '0};
      end
      else
      begin
         if (fillEn)
         begin
            validArr[addr.idx][curWay] <= 1'b1;
            dirtyArr[addr.idx][curWay] <= 1'b0;
         end
         if (cpuStoreEn)
         begin
            dirtyArr[addr.idx][curWay] <= 1'b1;
         end
         if (lruEn)
         begin
            lruArr[addr.idx] <= ~curWay;   // other way becomes least recent
         end
         if (flushInvEn)
         begin
            validArr[flushSet][flushWay] <= 1'b0;
            dirtyArr[flushSet][flushWay] <= 1'b0;
         end
      end
   end

   assign wayTag   = tagArr[addr.idx];
   assign wayValid = validArr[addr.idx];
   assign wayDirty = dirtyArr[addr.idx];
   assign lru      = lruArr[addr.idx];
   assign wayData  = dataArr[addr.idx];

   assign flushTag   = tagArr[flushSet][flushWay];
   assign flushValid = validArr[flushSet][flushWay];
   assign flushDirty = dirtyArr[flushSet][flushWay];
   assign flushData  = dataArr[flushSet][flushWay];

   // bypass the bus word on the final fill transfer
   assign dmemload = (fillEn & ~fillOther) ? dload : dataArr[addr.idx][curWay][addr.blkOff];

   fillFlushExclusive: assert property (@(posedge CLK) disable iff (!nRST)
      !(fillEn && flushInvEn));

endmodule

// File: dcache/memPort.sv
// memory bus driver
//   word addresses and enables for write-back, fill and flush transfers
//   store word select from the request set or the flush port
`timescale 1ns/1ps

module memPort
   import dcachePkg::*;
(
   input  logic       CLK,
   input  logic       nRST,
   input  wordT       dmemaddr,
   input  cacheStateT state,
   input  logic       curWay,
   input  tagT        wayTag [2],
   input  wordT       wayData [2][2],
   input  idxT        flushSet,
   input  tagT        flushTag,
   input  wordT       flushData [2],
   input  logic       flushDirty,
   input  logic       flushValid,
   output logic       dREN,
   output logic       dWEN,
   output wordT       daddr,
   output wordT       dstore
);

   cacheAddrT addr;

   assign addr = cacheAddrT'(dmemaddr);

   always_comb
   begin
      dREN   = 1'b0;
      dWEN   = 1'b0;
      daddr  = '0;
      dstore = '0;
      case (state)
         writeBack1, writeBack2:
         begin
            dWEN   = 1'b1;
            daddr  = {wayTag[curWay], addr.idx, state == writeBack2, {byteOffW{1'b0}}};
            dstore = wayData[curWay][state == writeBack2];
         end
         fill1, fill2:
         begin
            dREN  = 1'b1;
            daddr = {addr.tag, addr.idx, addr.blkOff ^ (state == fill1), {byteOffW{1'b0}}};
         end
         flush1, flush2:
         begin
            dWEN   = (state == flush2) | (flushValid & flushDirty);   // skip clean blocks
            daddr  = {flushTag, flushSet, state == flush2, {byteOffW{1'b0}}};
            dstore = flushData[state == flush2];
         end
         default: ;
      endcase
   end

   busEnableExclusive: assert property (@(posedge CLK) disable iff (!nRST)
      !(dREN && dWEN));

endmodule

// File: dcache/missControl.sv
// cache controller FSM
//   same-cycle hits, dirty victim write-back, two-word fill
//   flush walk over all sets and ways on halt, flushed level
`timescale 1ns/1ps

module missControl
   import dcachePkg::*;
(
   input  logic       CLK,
   input  logic       nRST,
   input  logic       dmemREN,
   input  logic       dmemWEN,
   input  logic       halt,
   input  logic       dwait,
   input  logic       hit,
   input  logic       hitWay,
   input  logic       victimWay,
   input  logic       victimDirty,
   input  logic       flushValid,
   input  logic       flushDirty,
   output cacheStateT state,
   output logic       curWay,
   output logic       fillEn,
   output logic       fillOther,
   output logic       cpuStoreEn,
   output logic       lruEn,
   output logic       flushInvEn,
   output logic       dhit,
   output logic       flushed,
   output idxT        flushSet,
   output logic       flushWay
);

   cacheStateT nextState;
   logic       wayReg, nextWay;
   idxT        nextSet;
   logic       nextFlushWay;
   logic       stepFlush;
   logic       request;

   assign request = dmemREN | dmemWEN;
   assign curWay  = (state == idle) ? hitWay : wayReg;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state    <= idle;
         wayReg   <= 1'b0;
         flushSet <= '0;
         flushWay <= 1'b0;
         flushed  <= 1'b0;
      end
      else
      begin
         state    <= nextState;
         wayReg   <= nextWay;
         flushSet <= nextSet;
         flushWay <= nextFlushWay;
         flushed  <= (nextState == halted);
      end
   end

   always_comb
   begin
      nextState  = state;
      nextWay    = wayReg;
      fillEn     = 1'b0;
      fillOther  = 1'b0;
      cpuStoreEn = 1'b0;
      lruEn      = 1'b0;
      flushInvEn = 1'b0;
      dhit       = 1'b0;
      stepFlush  = 1'b0;
      case (state)
         idle:
         begin
            dhit = ~request | hit;
            if (request && hit)
            begin
               lruEn      = 1'b1;
               cpuStoreEn = dmemWEN;
            end
            else if (request)
            begin
               nextWay   = victimWay;
               nextState = victimDirty ? writeBack1 : fill1;
            end
            else if (halt)
            begin
               nextState = flush1;
            end
         end
         writeBack1: nextState = dwait ? writeBack1 : writeBack2;
         writeBack2: nextState = dwait ? writeBack2 : fill1;
         fill1:
         begin
            fillEn    = ~dwait;
            fillOther = 1'b1;   // neighbor word first
            nextState = dwait ? fill1 : fill2;
         end
         fill2:
         begin
            fillEn     = ~dwait;
            dhit       = ~dwait;
            lruEn      = ~dwait;
            cpuStoreEn = ~dwait & dmemWEN;
            nextState  = dwait ? fill2 : idle;
         end
         flush1:
         begin
            if (flushValid && flushDirty)
            begin
               nextState = dwait ? flush1 : flush2;
            end
            else
            begin
               flushInvEn = 1'b1;   // nothing to write back
               stepFlush  = 1'b1;
            end
         end
         flush2:
         begin
            flushInvEn = ~dwait;
            stepFlush  = ~dwait;
         end
         default: dhit = 1'b1;   // halted
      endcase
      if (stepFlush)
      begin
         nextState = (flushSet == idxT'(lastSet) && flushWay) ? halted : flush1;
      end
   end

   // flush starts at set 0 way 0, way 1 before the next set
   assign nextSet      = (state == idle) ? '0 : flushSet + idxT'(stepFlush & flushWay);
   assign nextFlushWay = (state == idle) ? 1'b0 : flushWay ^ stepFlush;

   haltedSticky: assert property (@(posedge CLK) disable iff (!nRST)
      state == halted |=> state == halted);

   flushedOnlyHalted: assert property (@(posedge CLK) disable iff (!nRST)
      flushed |-> state == halted);

endmodule

// File: dcache/tagLookup.sv
// request side tag compare
//   hit detection against both ways of the request set
//   victim way choice by recency and its dirty status
`timescale 1ns/1ps

module tagLookup
   import dcachePkg::*;
(
   input  wordT       dmemaddr,
   input  tagT        wayTag [2],
   input  logic [1:0] wayValid,
   input  logic [1:0] wayDirty,
   input  logic       lru,
   output logic       hit,
   output logic       hitWay,
   output logic       victimWay,
   output logic       victimDirty
);

   cacheAddrT  addr;
   logic [1:0] match;

   assign addr = cacheAddrT'(dmemaddr);

   always_comb
   begin
      for (int w = 0; w < 2; w++)
      begin
         match[w] = wayValid[w] & (wayTag[w] == addr.tag);
      end
   end

   assign hit    = |match;
   assign hitWay = match[1];   // way 0 when no match

   // prefer the more recent way only if it is empty
   always_comb
   begin
      if (!wayValid[~lru])
      begin
         victimWay = ~lru;
      end
      else
      begin
         victimWay = lru;
      end
   end

   assign victimDirty = wayValid[victimWay] & wayDirty[victimWay];

endmodule

// File: runSim.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert --top-module dcacheTb -f vlog.f -o dcacheSim \
   && ./obj_dir/dcacheSim \
   || { echo "simulation failed" >&2; exit 1; }

// File: tb/dcacheTests.svh
// directed tests for the data cache
//   reference model of tags, valid, dirty and recency bits per set
//   CPU view of every memory word for expected read data
//   access task with hit and bus transfer checks, flush task
//   tests for hits, eviction order, write miss, random traffic and halt
`ifndef DCACHE_TESTS_SVH
`define DCACHE_TESTS_SVH

   tagT  mTag    [nSets][2];
   logic mValid  [nSets][2];
   logic mDirty  [nSets][2];
   logic mLru    [nSets];   // least recent way per set
   wordT cpuView [256];

   function automatic wordT makeAddr(input int tag, input int set, input int word);
      return wordT'((tag << 6) | (set << 3) | (word << 2));
   endfunction

   task automatic resetModel();
      for (int s = 0; s < nSets; s++)
      begin
         mLru[s] = 1'b0;
         for (int w = 0; w < 2; w++)
         begin
            mTag[s][w]   = '0;
            mValid[s][w] = 1'b0;
            mDirty[s][w] = 1'b0;
         end
      end
      for (int i = 0; i < 256; i++)
      begin
         cpuView[i] = initWord(8'(i));
      end
   endtask

   task automatic access(input logic isWrite, input wordT addr, input wordT data);
      cacheAddrT a;
      logic      way;
      logic      expHit;
      logic      expWb;
      int        readsBefore;
      int        writesBefore;
      int        waited;
      a      = cacheAddrT'(addr);
      expWb  = 1'b0;
      expHit = 1'b1;
      if (mValid[a.idx][0] && mTag[a.idx][0] == a.tag)
      begin
         way = 1'b0;
      end
      else if (mValid[a.idx][1] && mTag[a.idx][1] == a.tag)
      begin
         way = 1'b1;
      end
      else
      begin
         expHit = 1'b0;
         way    = mValid[a.idx][~mLru[a.idx]] ? mLru[a.idx] : ~mLru[a.idx];
         expWb  = mValid[a.idx][way] && mDirty[a.idx][way];
         mTag[a.idx][way]   = a.tag;
         mValid[a.idx][way] = 1'b1;
         mDirty[a.idx][way] = 1'b0;
      end
      if (isWrite)
      begin
         mDirty[a.idx][way] = 1'b1;
      end
      mLru[a.idx]  = ~way;
      readsBefore  = readCount;
      writesBefore = writeCount;
      waited       = 0;
      dmemaddr     = addr;
      dmemstore    = data;
      dmemREN      = ~isWrite;
      dmemWEN      = isWrite;
      @(negedge CLK);
      while (!dhit)
      begin
         waited = waited + 1;
         @(negedge CLK);
      end
      if (!isWrite)
      begin
         check(dmemload, cpuView[addr[9:2]], "read data");
      end
      if (expHit)
      begin
         check(32'(waited), 32'd0, "hit not answered in the same cycle");
      end
      @(posedge CLK);
      #1;
      dmemREN = 1'b0;
      dmemWEN = 1'b0;
      check(32'(readCount - readsBefore), expHit ? 32'd0 : 32'd2, "bus read count");
      check(32'(writeCount - writesBefore), expWb ? 32'd2 : 32'd0, "bus write count");
      if (isWrite)
      begin
         cpuView[addr[9:2]] = data;
      end
   endtask

   task automatic flushAll();
      int dirtyBlocks;
      int writesBefore;
      dirtyBlocks = 0;
      for (int s = 0; s < nSets; s++)
      begin
         for (int w = 0; w < 2; w++)
         begin
            if (mValid[s][w] && mDirty[s][w])
            begin
               dirtyBlocks = dirtyBlocks + 1;
            end
         end
      end
      writesBefore = writeCount;
      halt = 1'b1;
      @(negedge CLK);
      while (!flushed)
      begin
         @(negedge CLK);
      end
      check(32'(dhit), 32'd1, "dhit low after flush");
      check(32'(writeCount - writesBefore), 32'(2 * dirtyBlocks), "flush write count");
      for (int i = 0; i < 256; i++)
      begin
         check(mem[i], cpuView[i], "memory word after flush");
      end
   endtask

   task automatic readMissThenNeighbor();
      access(1'b0, makeAddr(1, 1, 0), '0);   // miss, two bus reads
      access(1'b0, makeAddr(1, 1, 1), '0);   // neighbor already filled
   endtask

   task automatic writeHitDeferred();
      wordT addr;
      addr = makeAddr(1, 1, 0);
      access(1'b1, addr, 32'hCAFE_0001);
      access(1'b0, addr, '0);
      check(mem[addr[9:2]], initWord(addr[9:2]), "memory written before eviction");
   endtask

   task automatic lruEviction();
      wordT addrA;
      wordT addrB;
      wordT addrC;
      addrA = makeAddr(2, 2, 0);
      addrB = makeAddr(3, 2, 0);
      addrC = makeAddr(4, 2, 0);
      access(1'b0, addrA, '0);
      access(1'b1, addrB, 32'hBEEF_0002);   // B dirty
      access(1'b0, addrA, '0);
      access(1'b0, addrC, '0);              // B is least recent
      access(1'b0, addrA, '0);
      check(mem[addrB[9:2]], 32'hBEEF_0002, "evicted dirty block in memory");
   endtask

   task automatic writeMissAllocate();
      access(1'b1, makeAddr(5, 3, 1), 32'h0DD0_0004);
      access(1'b0, makeAddr(5, 3, 1), '0);
      access(1'b0, makeAddr(5, 3, 0), '0);   // neighbor from memory
   endtask

   task automatic randomTraffic(input int count);
      wordT r;
      wordT addr;
      for (int n = 0; n < count; n++)
      begin
         r    = nextRandom();
         addr = makeAddr(int'(r[5:4]), int'(r[8:6]), int'(r[9]));
         access(r[0], addr, nextRandom());
      end
   endtask

`endif

// File: tb/dcacheTb.sv
// testbench for the data cache
//   clock, reset and DUT instance
//   word memory with random wait states and transfer counters
//   bus hold check during waits, timeout and the compare task
`timescale 1ns/1ps

module dcacheTb
   import dcachePkg::*;
();

   // about 60 accesses at up to 22 cycles each plus a 16 block flush and reset
   localparam int timeoutCycles = 4000;

   logic        CLK, nRST;
   logic        dmemREN, dmemWEN, halt, dhit, flushed;
   wordT        dmemaddr, dmemstore, dmemload;
   logic        dREN, dWEN, dwait;
   wordT        daddr, dstore, dload;
   wordT        mem [256];
   int          readCount, writeCount;
   int          waitLeft;
   int          cycleCount;
   logic        holding, heldRen, heldWen;
   wordT        heldAddr, heldStore;
   logic [31:0] rngState;

   dcacheTop uut (.*);

   assign dload = mem[daddr[9:2]];

   initial
   begin
      CLK = 1'b0;
      forever #5 CLK = ~CLK;
   end

   function automatic wordT nextRandom();
      rngState = rngState ^ (rngState << 13);   // xorshift32
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   // power-up memory contents spread over the byte address
   function automatic wordT initWord(input logic [7:0] word);
      return {22'b0, word, 2'b00} * 32'h9E37_79B1 + 32'h1357_9BDF;
   endfunction

   task automatic check(input wordT actual, input wordT expected, input string what);
      if (actual !== expected)
      begin
         $display("ERROR at %0d ns: %s: got %h, expected %h", $time, what, actual, expected);
         $display("=== FAIL ===");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // memory model sampled mid-cycle where the bus outputs are stable
   always @(negedge CLK)
   begin
      if (holding)
      begin
         check(32'({dREN, dWEN}), 32'({heldRen, heldWen}), "bus enables changed during wait");
         check(daddr, heldAddr, "bus address changed during wait");
         if (dWEN)
         begin
            check(dstore, heldStore, "store word changed during wait");
         end
      end
      holding = 1'b0;
      if (nRST && (dREN || dWEN))
      begin
         if (dwait)
         begin
            holding   = 1'b1;
            heldRen   = dREN;
            heldWen   = dWEN;
            heldAddr  = daddr;
            heldStore = dstore;
            waitLeft  = waitLeft - 1;
         end
         else
         begin
            if (dWEN)
            begin
               mem[daddr[9:2]] = dstore;
               writeCount = writeCount + 1;
            end
            else
            begin
               readCount = readCount + 1;
            end
            waitLeft = int'(nextRandom() % 4);   // waits for the next transfer
         end
      end
   end

   always @(posedge CLK)
   begin
      #1 dwait = (waitLeft != 0);
   end

   always @(posedge CLK)
   begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= timeoutCycles)
      begin
         $display("timeout: the cache stopped responding after %0d cycles", cycleCount);
         $display("=== FAIL ===");
         $fatal(1, "run ended by timeout");
      end
   end

   `include "dcacheTests.svh"

   initial
   begin
      nRST       = 1'b0;
      dmemREN    = 1'b0;
      dmemWEN    = 1'b0;
      halt       = 1'b0;
      dmemaddr   = '0;
      dmemstore  = '0;
      dwait      = 1'b0;
      waitLeft   = 0;
      holding    = 1'b0;
      readCount  = 0;
      writeCount = 0;
      cycleCount = 0;
      rngState   = 32'd79;
      for (int i = 0; i < 256; i++)
      begin
         mem[i] = initWord(8'(i));
      end
      resetModel();
      repeat (16) @(posedge CLK);
      #1 nRST = 1'b1;
      @(negedge CLK);
      check(32'({dREN, dWEN, flushed}), 32'd0, "bus enables or flushed high after reset");
      check(32'(dhit), 32'd1, "dhit low with no request");
      @(posedge CLK);
      #1;
      readMissThenNeighbor();
      writeHitDeferred();
      lruEviction();
      writeMissAllocate();
      randomTraffic(40);
      flushAll();
      $display("=== PASS ===");
      $finish;
   end

endmodule

// File: vlog.f
+incdir+tb
common/dcachePkg.sv
dcache/tagLookup.sv
dcache/frameStore.sv
dcache/missControl.sv
dcache/memPort.sv
dcache/dcacheTop.sv
tb/dcacheTb.sv
